//--- include/r24bb_config.svh
`ifndef R24BB_CONFIG_SVH
`define R24BB_CONFIG_SVH

//////////////////////////////////////////////////
// Data path widths
//////////////////////////////////////////////////
`define R24BB_SAMPLE_W 8   // ADC, DAC and DDS sample
`define R24BB_PHASE_W 32   // DDS accumulator, also the control word
`define R24BB_APB_AW 16    // Page in the top nibble
`define R24BB_APB_DW 32
`define R24BB_PAGE_W 4
`define R24BB_SRC_W 3

// Register pages, offset inside a page is ignored
`define R24BB_PAGE_INA 4'd0
`define R24BB_PAGE_INB 4'd1
`define R24BB_PAGE_OUTA 4'd2
`define R24BB_PAGE_OUTB 4'd3
`define R24BB_PAGE_STATUS 4'd4
`define R24BB_PAGE_DDSA 4'd5
`define R24BB_PAGE_DDSB 4'd6

// DAC source codes, 5..7 also mute
`define R24BB_SRC_INA 3'd0
`define R24BB_SRC_INB 3'd1
`define R24BB_SRC_DDSA 3'd2
`define R24BB_SRC_DDSB 3'd3
`define R24BB_SRC_MUTE 3'd4

`define R24BB_OVR_HOLD 16  // Cycles the overrange flag outlives the raw dor

`endif

//--- design/r24bb_pkg.sv
`default_nettype none

`include "r24bb_config.svh"

package r24bb_pkg;

    // One APB write word, seen either as DDS increment or as channel control
    typedef union packed {
        logic [`R24BB_PHASE_W-1:0] raw;         // DDS phase increment
        struct packed {
            logic [`R24BB_PHASE_W-10:0] rsvd;   // Reads back as zero
            logic [`R24BB_SRC_W-1:0]    src;    // DAC source, out pages only
            logic [2:0]                 led;    // Bit 2 is red
            logic                       amp_en;
            logic [1:0]                 att;
        } chan;
    } ctrl_word_u;

    // One byte of an IO expander word
    // LEDs and attenuator pins are active low, amp enable is not
    function automatic logic [7:0] io_byte(
        input logic [1:0] att,
        input logic       amp_en,
        input logic [2:0] led,
        input logic       red_on    // Overrange forces red LED on
    );
        logic [2:0] led_on;
        led_on = led | {red_on, 2'b00};
        return {2'b00, ~led_on, amp_en, ~att};
    endfunction

endpackage

`default_nettype wire

//--- design/r24bb_regs.sv
`default_nettype none

`include "r24bb_config.svh"

module r24bb_regs import r24bb_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       arst_n_i,

    // APB slave, pready tied high
    input  wire logic [`R24BB_APB_AW-1:0]   paddr_i,
    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [`R24BB_APB_DW-1:0]   pwdata_i,
    output logic [`R24BB_APB_DW-1:0]        prdata_o,

    // Held overrange flags for the status page
    input  wire logic                       ovr_a_i,
    input  wire logic                       ovr_b_i,

    output logic [1:0]                      ina_att_o,
    output logic                            ina_amp_en_o,
    output logic [2:0]                      ina_led_o,
    output logic [1:0]                      inb_att_o,
    output logic                            inb_amp_en_o,
    output logic [2:0]                      inb_led_o,
    output logic [1:0]                      outa_att_o,
    output logic                            outa_amp_en_o,
    output logic [2:0]                      outa_led_o,
    output logic [1:0]                      outb_att_o,
    output logic                            outb_amp_en_o,
    output logic [2:0]                      outb_led_o,
    output logic [`R24BB_SRC_W-1:0]         outa_src_o,
    output logic [`R24BB_SRC_W-1:0]         outb_src_o,

    output logic [`R24BB_PHASE_W-1:0]       ddsa_inc_o,
    output logic [`R24BB_PHASE_W-1:0]       ddsb_inc_o
);

    ctrl_word_u wdata;                          // pwdata, both views
    ctrl_word_u ina_q, inb_q, outa_q, outb_q;   // Channel control words
    logic [`R24BB_PHASE_W-1:0] ddsa_q, ddsb_q;  // DDS increments
    logic [`R24BB_PAGE_W-1:0]  page;
    logic                      access;          // APB access phase
    logic [`R24BB_APB_DW-1:0]  rdata;

    // Keeps only the defined control fields, src only on output pages
    function automatic ctrl_word_u chan_fields(input ctrl_word_u w, input logic keep_src);
        ctrl_word_u r;
        r = '0;
        r.chan.att    = w.chan.att;
        r.chan.amp_en = w.chan.amp_en;
        r.chan.led    = w.chan.led;
        r.chan.src    = keep_src ? w.chan.src : '0;
        return r;
    endfunction

    assign wdata.raw = pwdata_i;
    assign page      = paddr_i[`R24BB_APB_AW-1 -: `R24BB_PAGE_W];  // Top nibble
    assign access    = psel_i && penable_i;

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ina_q  <= '0;
            inb_q  <= '0;
            outa_q <= '0;  // src 0 selects ina
            outb_q <= '0;
            ddsa_q <= '0;
            ddsb_q <= '0;
        end else if (access && pwrite_i) begin  // Takes effect at end of access
            case (page)
                `R24BB_PAGE_INA:  ina_q  <= chan_fields(wdata, 1'b0);
                `R24BB_PAGE_INB:  inb_q  <= chan_fields(wdata, 1'b0);
                `R24BB_PAGE_OUTA: outa_q <= chan_fields(wdata, 1'b1);
                `R24BB_PAGE_OUTB: outb_q <= chan_fields(wdata, 1'b1);
                `R24BB_PAGE_DDSA: ddsa_q <= wdata.raw;
                `R24BB_PAGE_DDSB: ddsb_q <= wdata.raw;
                default: ;       // Status page is read only
            endcase
        end
    end

    // Readback mux, combinational in the access phase
    always_comb begin
        rdata = '0;
        if (access) begin
            case (page)
                `R24BB_PAGE_INA:    rdata = ina_q.raw;
                `R24BB_PAGE_INB:    rdata = inb_q.raw;
                `R24BB_PAGE_OUTA:   rdata = outa_q.raw;
                `R24BB_PAGE_OUTB:   rdata = outb_q.raw;
                `R24BB_PAGE_STATUS: rdata = {{(`R24BB_APB_DW-2){1'b0}}, ovr_b_i, ovr_a_i};
                `R24BB_PAGE_DDSA:   rdata = ddsa_q;
                `R24BB_PAGE_DDSB:   rdata = ddsb_q;
                default:            rdata = '0;   // Unused pages
            endcase
        end
    end

    assign prdata_o = rdata;

    // Field fan-out
    assign ina_att_o     = ina_q.chan.att;
    assign ina_amp_en_o  = ina_q.chan.amp_en;
    assign ina_led_o     = ina_q.chan.led;
    assign inb_att_o     = inb_q.chan.att;
    assign inb_amp_en_o  = inb_q.chan.amp_en;
    assign inb_led_o     = inb_q.chan.led;
    assign outa_att_o    = outa_q.chan.att;
    assign outa_amp_en_o = outa_q.chan.amp_en;
    assign outa_led_o    = outa_q.chan.led;
    assign outb_att_o    = outb_q.chan.att;
    assign outb_amp_en_o = outb_q.chan.amp_en;
    assign outb_led_o    = outb_q.chan.led;
    assign outa_src_o    = outa_q.chan.src;
    assign outb_src_o    = outb_q.chan.src;
    assign ddsa_inc_o    = ddsa_q;
    assign ddsb_inc_o    = ddsb_q;

endmodule

`default_nettype wire

//--- design/adc_capture.sv
`default_nettype none

`include "r24bb_config.svh"

module adc_capture import r24bb_pkg::*; (
    input  wire logic                         clk_i,
    input  wire logic                         arst_n_i,

    // ADC pins, one word per clock
    input  wire logic [`R24BB_SAMPLE_W-1:0]   adc_a_i,
    input  wire logic                         dor_a_i,
    input  wire logic [`R24BB_SAMPLE_W-1:0]   adc_b_i,
    input  wire logic                         dor_b_i,

    // Front-end control from the register bank
    input  wire logic [1:0]                   ina_att_i,
    input  wire logic                         ina_amp_en_i,
    input  wire logic [2:0]                   ina_led_i,
    input  wire logic [1:0]                   inb_att_i,
    input  wire logic                         inb_amp_en_i,
    input  wire logic [2:0]                   inb_led_i,

    output logic [`R24BB_SAMPLE_W-1:0]        ina_data_o,
    output logic [`R24BB_SAMPLE_W-1:0]        inb_data_o,
    output logic                              ovr_a_o,     // Held overrange
    output logic                              ovr_b_o,
    output logic [15:0]                       adc_io_o     // IO expander word
);

    localparam int HOLD_W = $clog2(`R24BB_OVR_HOLD + 1);
    localparam logic [HOLD_W-1:0] HOLD_INIT = HOLD_W'(`R24BB_OVR_HOLD);

    logic [1:0]             dor_raw;
    logic [1:0][HOLD_W-1:0] hold_cnt;   // Index 0 is channel a

    assign dor_raw = {dor_b_i, dor_a_i};

    //////////////////////////////////////////////////
    // Sample capture and overrange stretch
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ina_data_o <= '0;
            inb_data_o <= '0;
            hold_cnt   <= '0;
        end else begin
            ina_data_o <= adc_a_i;  // One cycle pin to sample
            inb_data_o <= adc_b_i;
            for (int i = 0; i < 2; i++) begin
                if (dor_raw[i])
                    hold_cnt[i] <= HOLD_INIT;          // Retrigger on every dor
                else if (hold_cnt[i] != '0)
                    hold_cnt[i] <= hold_cnt[i] - 1'b1;
            end
        end
    end

    assign ovr_a_o = (hold_cnt[0] != '0);
    assign ovr_b_o = (hold_cnt[1] != '0);

    // Expander word, inb byte on top, red LED lit while flag held
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            adc_io_o <= '0;
        else
            adc_io_o <= {io_byte(inb_att_i, inb_amp_en_i, inb_led_i, ovr_b_o),
                         io_byte(ina_att_i, ina_amp_en_i, ina_led_i, ovr_a_o)};
    end

endmodule

`default_nettype wire

//--- design/dds_gen.sv
`default_nettype none

`include "r24bb_config.svh"

// Sawtooth DDS
// Phase wraps naturally at 2^PHASE_W, so output period is 2^PHASE_W / inc cycles
module dds_gen (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic [`R24BB_PHASE_W-1:0]   inc_i,      // Phase step per clock
    output logic [`R24BB_SAMPLE_W-1:0]       sample_o    // Two's complement
);

    localparam int PW = `R24BB_PHASE_W;
    localparam int SW = `R24BB_SAMPLE_W;

    logic [PW-1:0] phase_q;  // Accumulator
    logic [PW-1:0] phase_d;

    //////////////////////////////////////////////////
    // Phase accumulator
    //////////////////////////////////////////////////

    // Modulo add, carry out dropped on purpose
    assign phase_d = phase_q + inc_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            phase_q <= '0;   // Starts at phase zero
        else
            phase_q <= phase_d;  // Advance every clock, no enable
    end

    //////////////////////////////////////////////////
    // Waveform
    //////////////////////////////////////////////////

    // Top byte of phase is the ramp
    // 0x00..0x7F positive half, 0x80..0xFF negative half when read signed
    // Step between samples is inc[PW-1 -: SW] when the low bits of inc are zero
    assign sample_o = phase_q[PW-1 -: SW];

endmodule

`default_nettype wire

//--- design/dac_output.sv
`default_nettype none

`include "r24bb_config.svh"

module dac_output import r24bb_pkg::*; (
    input  wire logic                         clk_i,
    input  wire logic                         arst_n_i,

    // Candidate sources
    input  wire logic [`R24BB_SAMPLE_W-1:0]   ina_data_i,
    input  wire logic [`R24BB_SAMPLE_W-1:0]   inb_data_i,
    input  wire logic [`R24BB_SAMPLE_W-1:0]   ddsa_data_i,
    input  wire logic [`R24BB_SAMPLE_W-1:0]   ddsb_data_i,

    input  wire logic [`R24BB_SRC_W-1:0]      outa_src_i,
    input  wire logic [`R24BB_SRC_W-1:0]      outb_src_i,

    // Back-end control from the register bank
    input  wire logic [1:0]                   outa_att_i,
    input  wire logic                         outa_amp_en_i,
    input  wire logic [2:0]                   outa_led_i,
    input  wire logic [1:0]                   outb_att_i,
    input  wire logic                         outb_amp_en_i,
    input  wire logic [2:0]                   outb_led_i,

    output logic [`R24BB_SAMPLE_W-1:0]        dac_a_o,
    output logic [`R24BB_SAMPLE_W-1:0]        dac_b_o,
    output logic [15:0]                       dac_io_o     // IO expander word
);

    logic [`R24BB_SAMPLE_W-1:0] dac_a_d;
    logic [`R24BB_SAMPLE_W-1:0] dac_b_d;

    // Source multiplexer, shared by both channels
    function automatic logic [`R24BB_SAMPLE_W-1:0] src_mux(
        input logic [`R24BB_SRC_W-1:0]    src,
        input logic [`R24BB_SAMPLE_W-1:0] ina,
        input logic [`R24BB_SAMPLE_W-1:0] inb,
        input logic [`R24BB_SAMPLE_W-1:0] ddsa,
        input logic [`R24BB_SAMPLE_W-1:0] ddsb
    );
        case (src)
            `R24BB_SRC_INA:  return ina;
            `R24BB_SRC_INB:  return inb;
            `R24BB_SRC_DDSA: return ddsa;
            `R24BB_SRC_DDSB: return ddsb;
            `R24BB_SRC_MUTE: return '0;
            default:         return '0;   // 5..7 mute as well
        endcase
    endfunction

    assign dac_a_d = src_mux(outa_src_i, ina_data_i, inb_data_i, ddsa_data_i, ddsb_data_i);
    assign dac_b_d = src_mux(outb_src_i, ina_data_i, inb_data_i, ddsa_data_i, ddsb_data_i);

    //////////////////////////////////////////////////
    // DAC output registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dac_a_o <= '0;
            dac_b_o <= '0;
        end else begin
            dac_a_o <= dac_a_d;   // Second stage of ADC to DAC path
            dac_b_o <= dac_b_d;
        end
    end

    // Expander word, outb byte on top, no overrange forcing on outputs
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            dac_io_o <= '0;
        else
            dac_io_o <= {io_byte(outb_att_i, outb_amp_en_i, outb_led_i, 1'b0),
                         io_byte(outa_att_i, outa_amp_en_i, outa_led_i, 1'b0)};
    end

endmodule

`default_nettype wire

//--- design/r24bb_top.sv
`default_nettype none

`include "r24bb_config.svh"

module r24bb_top (
    input  wire logic                         clk_i,
    input  wire logic                         arst_n_i,

    // APB from the host
    input  wire logic [`R24BB_APB_AW-1:0]     paddr_i,
    input  wire logic                         psel_i,
    input  wire logic                         penable_i,
    input  wire logic                         pwrite_i,
    input  wire logic [`R24BB_APB_DW-1:0]     pwdata_i,
    output logic [`R24BB_APB_DW-1:0]          prdata_o,

    // ADC pins
    input  wire logic [`R24BB_SAMPLE_W-1:0]   adc_a_i,
    input  wire logic                         dor_a_i,
    input  wire logic [`R24BB_SAMPLE_W-1:0]   adc_b_i,
    input  wire logic                         dor_b_i,

    // DAC pins and expander words
    output logic [`R24BB_SAMPLE_W-1:0]        dac_a_o,
    output logic [`R24BB_SAMPLE_W-1:0]        dac_b_o,
    output logic [15:0]                       adc_io_o,
    output logic [15:0]                       dac_io_o
);

    // Channel control
    logic [1:0] ina_att, inb_att, outa_att, outb_att;
    logic       ina_amp_en, inb_amp_en, outa_amp_en, outb_amp_en;
    logic [2:0] ina_led, inb_led, outa_led, outb_led;
    logic [`R24BB_SRC_W-1:0]   outa_src, outb_src;
    logic [`R24BB_PHASE_W-1:0] ddsa_inc, ddsb_inc;

    // Sample paths
    logic [`R24BB_SAMPLE_W-1:0] ina_data, inb_data, ddsa_data, ddsb_data;
    logic ovr_a, ovr_b;

    r24bb_regs regs_inst (
        .clk_i, .arst_n_i,
        .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i, .prdata_o,
        .ovr_a_i(ovr_a), .ovr_b_i(ovr_b),
        .ina_att_o(ina_att), .ina_amp_en_o(ina_amp_en), .ina_led_o(ina_led),
        .inb_att_o(inb_att), .inb_amp_en_o(inb_amp_en), .inb_led_o(inb_led),
        .outa_att_o(outa_att), .outa_amp_en_o(outa_amp_en), .outa_led_o(outa_led),
        .outb_att_o(outb_att), .outb_amp_en_o(outb_amp_en), .outb_led_o(outb_led),
        .outa_src_o(outa_src), .outb_src_o(outb_src),
        .ddsa_inc_o(ddsa_inc), .ddsb_inc_o(ddsb_inc)
    );

    adc_capture adc_inst (
        .clk_i, .arst_n_i,
        .adc_a_i, .dor_a_i, .adc_b_i, .dor_b_i,
        .ina_att_i(ina_att), .ina_amp_en_i(ina_amp_en), .ina_led_i(ina_led),
        .inb_att_i(inb_att), .inb_amp_en_i(inb_amp_en), .inb_led_i(inb_led),
        .ina_data_o(ina_data), .inb_data_o(inb_data),
        .ovr_a_o(ovr_a), .ovr_b_o(ovr_b),
        .adc_io_o
    );

    dds_gen ddsa (.clk_i, .arst_n_i, .inc_i(ddsa_inc), .sample_o(ddsa_data));
    dds_gen ddsb (.clk_i, .arst_n_i, .inc_i(ddsb_inc), .sample_o(ddsb_data));

    dac_output dac_inst (
        .clk_i, .arst_n_i,
        .ina_data_i(ina_data), .inb_data_i(inb_data),
        .ddsa_data_i(ddsa_data), .ddsb_data_i(ddsb_data),
        .outa_src_i(outa_src), .outb_src_i(outb_src),
        .outa_att_i(outa_att), .outa_amp_en_i(outa_amp_en), .outa_led_i(outa_led),
        .outb_att_i(outb_att), .outb_amp_en_i(outb_amp_en), .outb_led_i(outb_led),
        .dac_a_o, .dac_b_o,
        .dac_io_o
    );

endmodule

`default_nettype wire

//--- verif/r24bb_sva.sv
`default_nettype none

`include "r24bb_config.svh"

module r24bb_sva (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic [15:0] adc_io_i,
    input  wire logic [15:0] dac_io_i,
    input  wire logic        ovr_a_i,     // Held overrange flags
    input  wire logic        ovr_b_i,
    input  wire logic [2:0]  outa_src_i,
    input  wire logic [2:0]  outb_src_i,
    input  wire logic [7:0]  dac_a_i,
    input  wire logic [7:0]  dac_b_i
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////
    // Expander words
    //////////////////////////////////////////////////
    a_io_pad: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        adc_io_i[7:6] == 2'b00 && adc_io_i[15:14] == 2'b00 &&
        dac_io_i[7:6] == 2'b00 && dac_io_i[15:14] == 2'b00)
        else $error("Expander byte with bits 7..6 set");

    // Word is registered, so red follows the flag by one cycle
    a_red_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ovr_a_i |=> !adc_io_i[5])
        else $error("Red LED of ina off while overrange held");
    a_red_b: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ovr_b_i |=> !adc_io_i[13])
        else $error("Red LED of inb off while overrange held");

    //////////////////////////////////////////////////
    // Mute codes 4 to 7
    //////////////////////////////////////////////////
    a_mute_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        outa_src_i >= `R24BB_SRC_MUTE |=> dac_a_i == 8'h00)
        else $error("dac_a nonzero after mute source");
    a_mute_b: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        outb_src_i >= `R24BB_SRC_MUTE |=> dac_b_i == 8'h00)
        else $error("dac_b nonzero after mute source");

endmodule

bind r24bb_top r24bb_sva sva_inst (
    .clk_i,
    .arst_n_i,
    .adc_io_i   (adc_io_o),
    .dac_io_i   (dac_io_o),
    .ovr_a_i    (ovr_a),
    .ovr_b_i    (ovr_b),
    .outa_src_i (outa_src),
    .outb_src_i (outb_src),
    .dac_a_i    (dac_a_o),
    .dac_b_i    (dac_b_o)
);

`default_nettype wire

//--- verif/r24bb_tb.sv
`default_nettype none

`include "r24bb_config.svh"

module r24bb_tb import r24bb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h8d7d;
    localparam int WAIT_LIMIT = `R24BB_OVR_HOLD + 8;  // Give up after this many cycles

    // DUT pins with known start values
    logic        clk_i     = 1'b0;
    logic        arst_n_i  = 1'b0;
    logic [15:0] paddr_i   = '0;
    logic        psel_i    = 1'b0;
    logic        penable_i = 1'b0;
    logic        pwrite_i  = 1'b0;
    logic [31:0] pwdata_i  = '0;
    logic [7:0]  adc_a_i   = '0;
    logic        dor_a_i   = 1'b0;
    logic [7:0]  adc_b_i   = '0;
    logic        dor_b_i   = 1'b0;
    logic [31:0] prdata_o;
    logic [7:0]  dac_a_o;
    logic [7:0]  dac_b_o;
    logic [15:0] adc_io_o;
    logic [15:0] dac_io_o;

    // Reference model state after the last rising edge
    logic [31:0] m_reg [0:15];     // Shadow of each page
    logic [31:0] m_phase [0:1];    // DDS accumulators
    logic [7:0]  m_cap [0:1];      // Captured ADC samples
    logic [7:0]  m_dac [0:1];
    logic [15:0] m_adc_io;
    logic [15:0] m_dac_io;
    int          m_hold [0:1];     // Overrange cycles left
    logic [31:0] adc_state  = SEED;
    logic [31:0] stim_state = SEED;
    int          errors = 0;
    int          checks = 0;

    r24bb_top DUT (.*);

    always #5 clk_i = ~clk_i;  // 10 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    //////////////////////////////////////////////////
    // Reference functions
    //////////////////////////////////////////////////
    // Only the defined fields survive a write
    function automatic logic [31:0] stored_value(input logic [3:0] page, input logic [31:0] d);
        case (page)
            `R24BB_PAGE_INA, `R24BB_PAGE_INB:   return d & 32'h0000_003f;  // att, amp, led
            `R24BB_PAGE_OUTA, `R24BB_PAGE_OUTB: return d & 32'h0000_01ff;  // Plus src
            default:                            return d;                   // DDS increment
        endcase
    endfunction

    function automatic logic [31:0] readback(input logic [3:0] page);
        case (page)
            `R24BB_PAGE_STATUS: return {30'b0, m_hold[1] != 0, m_hold[0] != 0};
            `R24BB_PAGE_INA, `R24BB_PAGE_INB, `R24BB_PAGE_OUTA, `R24BB_PAGE_OUTB,
            `R24BB_PAGE_DDSA, `R24BB_PAGE_DDSB: return m_reg[page];
            default:            return '0;  // Unused pages
        endcase
    endfunction

    function automatic logic [7:0] source_sample(input logic [2:0] src);
        case (src)
            `R24BB_SRC_INA:  return m_cap[0];
            `R24BB_SRC_INB:  return m_cap[1];
            `R24BB_SRC_DDSA: return m_phase[0][31:24];  // Top byte of phase
            `R24BB_SRC_DDSB: return m_phase[1][31:24];
            default:         return 8'h00;              // Codes 4 to 7 mute
        endcase
    endfunction

    // One expander byte from a stored control word
    function automatic logic [7:0] expander_byte(input logic [31:0] ctrl, input logic ovr);
        logic [7:0] b;
        b      = 8'h00;
        b[1:0] = ~ctrl[1:0];  // Attenuator pins active low
        b[2]   = ctrl[2];     // Amp enable as written
        b[5:3] = ~ctrl[5:3];  // LEDs active low
        if (ovr)
            b[5] = 1'b0;      // Red LED lit while held
        return b;
    endfunction

    function automatic logic red_pin(input int ch);
        return (ch == 0) ? adc_io_o[5] : adc_io_o[13];
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic reset_model();
        m_reg    = '{default: '0};
        m_phase  = '{default: '0};
        m_cap    = '{default: '0};
        m_dac    = '{default: '0};
        m_hold   = '{default: 0};
        m_adc_io = '0;
        m_dac_io = '0;
    endtask

    //////////////////////////////////////////////////
    // Compare, then step the model
    //////////////////////////////////////////////////
    always @(posedge clk_i) begin : compare
        logic [7:0]  dac_a_n;
        logic [7:0]  dac_b_n;
        logic [15:0] adc_io_n;
        logic [15:0] dac_io_n;
        logic [3:0]  page;
        page = paddr_i[15:12];
        if (!arst_n_i) begin
            reset_model();
        end else begin
            checks++;
            if (dac_a_o !== m_dac[0])
                report_mismatch("dac_a_o", 32'(dac_a_o), 32'(m_dac[0]));
            if (dac_b_o !== m_dac[1])
                report_mismatch("dac_b_o", 32'(dac_b_o), 32'(m_dac[1]));
            if (adc_io_o !== m_adc_io)
                report_mismatch("adc_io_o", 32'(adc_io_o), 32'(m_adc_io));
            if (dac_io_o !== m_dac_io)
                report_mismatch("dac_io_o", 32'(dac_io_o), 32'(m_dac_io));
            if (psel_i && penable_i && !pwrite_i && prdata_o !== readback(page))
                report_mismatch("prdata_o", prdata_o, readback(page));
            // Next values from the state before this edge
            dac_a_n  = source_sample(m_reg[`R24BB_PAGE_OUTA][8:6]);
            dac_b_n  = source_sample(m_reg[`R24BB_PAGE_OUTB][8:6]);
            adc_io_n = {expander_byte(m_reg[`R24BB_PAGE_INB], m_hold[1] != 0),
                        expander_byte(m_reg[`R24BB_PAGE_INA], m_hold[0] != 0)};
            dac_io_n = {expander_byte(m_reg[`R24BB_PAGE_OUTB], 1'b0),
                        expander_byte(m_reg[`R24BB_PAGE_OUTA], 1'b0)};
            m_dac[0]   = dac_a_n;
            m_dac[1]   = dac_b_n;
            m_adc_io   = adc_io_n;
            m_dac_io   = dac_io_n;
            m_phase[0] = m_phase[0] + m_reg[`R24BB_PAGE_DDSA];
            m_phase[1] = m_phase[1] + m_reg[`R24BB_PAGE_DDSB];
            m_cap[0]   = adc_a_i;
            m_cap[1]   = adc_b_i;
            m_hold[0]  = dor_a_i ? `R24BB_OVR_HOLD : (m_hold[0] > 0 ? m_hold[0] - 1 : 0);
            m_hold[1]  = dor_b_i ? `R24BB_OVR_HOLD : (m_hold[1] > 0 ? m_hold[1] - 1 : 0);
            if (psel_i && penable_i && pwrite_i) begin  // Write lands at end of access
                if (page <= `R24BB_PAGE_OUTB || page == `R24BB_PAGE_DDSA ||
                    page == `R24BB_PAGE_DDSB)
                    m_reg[page] = stored_value(page, pwdata_i);
            end
        end
    end

    // Fresh random ADC words on every falling edge
    always @(negedge clk_i) begin
        adc_state = lcg_next(adc_state);
        adc_a_i   = adc_state[23:16];
        adc_b_i   = adc_state[31:24];
    end

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////
    task automatic apb_xfer(input logic write, input logic [3:0] page, input logic [31:0] data);
        logic [31:0] w;
        w = rand_word();
        @(negedge clk_i);                // Setup phase
        paddr_i   = {page, w[11:0]};     // Offset ignored by the DUT
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        pwdata_i  = data;
        @(negedge clk_i);                // Access phase
        penable_i = 1'b1;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // Single dor pulse, then time how long the red pin stays low
    task automatic overrange_pulse(input int ch);
        int guard;
        int cycles;
        @(negedge clk_i);
        if (ch == 0)
            dor_a_i = 1'b1;
        else
            dor_b_i = 1'b1;
        @(negedge clk_i);
        dor_a_i = 1'b0;
        dor_b_i = 1'b0;
        guard = 0;
        while (red_pin(ch) !== 1'b0 && guard < WAIT_LIMIT) begin
            @(negedge clk_i);
            guard++;
        end
        cycles = 0;
        while (red_pin(ch) === 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (guard >= WAIT_LIMIT || cycles >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout: red LED of channel %0d did not light and clear after dor", ch);
        end else if (cycles < `R24BB_OVR_HOLD - 1 || cycles > `R24BB_OVR_HOLD + 1) begin
            errors++;
            $display("Mismatch at %0d ns: red LED of channel %0d lit %0d cycles, expected %0d",
                     $time, ch, cycles, `R24BB_OVR_HOLD);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        ctrl_word_u cw;
        repeat (4) @(negedge clk_i);
        arst_n_i = 1'b1;

        for (int p = 0; p < 16; p++)
            apb_xfer(1'b0, 4'(p), '0);           // Every page zero after reset
        for (int p = 0; p < 16; p++)
            apb_xfer(1'b1, 4'(p), rand_word());  // Status and unused pages ignore it
        for (int p = 0; p < 16; p++)
            apb_xfer(1'b0, 4'(p), '0);

        // ADC straight through
        cw = '0;
        cw.chan.src = `R24BB_SRC_INA;
        apb_xfer(1'b1, `R24BB_PAGE_OUTA, cw.raw);
        cw.chan.src = `R24BB_SRC_INB;
        apb_xfer(1'b1, `R24BB_PAGE_OUTB, cw.raw);
        idle(40);

        // Sawtooth steps of one top byte
        apb_xfer(1'b1, `R24BB_PAGE_DDSA, 32'h0500_0000);
        apb_xfer(1'b1, `R24BB_PAGE_DDSB, rand_word() & 32'hff00_0000);
        cw.chan.src = `R24BB_SRC_DDSA;
        apb_xfer(1'b1, `R24BB_PAGE_OUTA, cw.raw);
        cw.chan.src = `R24BB_SRC_DDSB;
        apb_xfer(1'b1, `R24BB_PAGE_OUTB, cw.raw);
        idle(30);
        for (int s = 4; s < 8; s++) begin
            cw.chan.src = 3'(s);
            apb_xfer(1'b1, `R24BB_PAGE_OUTA, cw.raw);
            apb_xfer(1'b1, `R24BB_PAGE_OUTB, cw.raw);
            idle(3);
        end

        // Front-end controls with red LEDs written off
        cw = '0;
        cw.chan.att    = 2'b01;
        cw.chan.amp_en = 1'b1;
        cw.chan.led    = 3'b011;
        apb_xfer(1'b1, `R24BB_PAGE_INA, cw.raw);
        apb_xfer(1'b1, `R24BB_PAGE_OUTB, cw.raw);
        cw.chan.att = 2'b10;
        cw.chan.led = 3'b001;
        apb_xfer(1'b1, `R24BB_PAGE_INB, cw.raw);
        apb_xfer(1'b1, `R24BB_PAGE_OUTA, cw.raw);
        overrange_pulse(0);
        overrange_pulse(1);

        @(negedge clk_i);
        dor_a_i = 1'b1;
        @(negedge clk_i);
        dor_a_i = 1'b0;
        apb_xfer(1'b0, `R24BB_PAGE_STATUS, '0);  // Flag still held
        idle(`R24BB_OVR_HOLD + 2);
        apb_xfer(1'b0, `R24BB_PAGE_STATUS, '0);  // Cleared again
        idle(4);

        $display("Compared %0d cycles, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- r24bb_top.f
+incdir+include
design/r24bb_pkg.sv
design/r24bb_regs.sv
design/adc_capture.sv
design/dds_gen.sv
design/dac_output.sv
design/r24bb_top.sv
verif/r24bb_sva.sv
verif/r24bb_tb.sv

//--- Makefile
TOP := r24bb_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove build output and sim.log"

obj_dir/V$(TOP): r24bb_top.f $(wildcard design/*.sv verif/*.sv include/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps -Iinclude \
		--top-module $(TOP) -f r24bb_top.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
